// ==== project.f ====
+incdir+.
regfile_pkg.sv
datapath_pkg.sv
hct74670.sv
register_file.sv
alu.sv
datapath_sequencer.sv
datapath_top.sv
datapath_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module datapath_tb -f project.f -o sim_datapath
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/sim_datapath
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit "$sim_status"
fi

echo "Simulation finished cleanly"
exit 0

// ==== datapath_tb.sv ====
// Every register is loaded before a row reads it, since reset leaves the registers undefined.
`timescale 1ns/1ns
`default_nettype none

module datapath_tb;

    import regfile_pkg::*;
    import datapath_pkg::*;

    logic       _wr_en;
    logic       reset;
    instr_t     instr;
    logic       instr_valid;
    reg_data_t  result;
    alu_flags_t flags;
    logic       result_valid;

    // Stimulus table. Entry i of every queue belongs to the same row.
    instr_t     row_instr[$];
    logic       row_valid[$];
    reg_data_t  row_result[$];
    alu_flags_t row_flags[$];
    string      row_name[$];

    datapath_top uut (
        ._wr_en       (_wr_en),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid)
    );

    initial begin
        _wr_en = 1'b0;
        forever #2 _wr_en = ~_wr_en; // 4 ns period.
    end

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_result(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s gave result 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flags(input alu_flags_t got, input alu_flags_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s gave carry %b zero %b, expected carry %b zero %b",
                     $time, what, got.carry, got.zero, exp.carry, exp.zero);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s gave result_valid %b, expected %b",
                     $time, what, got, exp);
            stop_on_error();
        end
    endtask

    function automatic instr_t load_word(input reg_addr_t dest, input reg_data_t value);
        instr_t word;
        word                   = '0;
        word.kind              = 1'b1;
        word.dest              = dest;
        word.payload.imm.value = value;
        return word;
    endfunction

    function automatic instr_t alu_word(input alu_op_t op, input reg_addr_t dest,
                                        input reg_addr_t src_l, input reg_addr_t src_r);
        instr_t word;
        word                   = '0;
        word.kind              = 1'b0;
        word.dest              = dest;
        word.payload.alu.op    = op;
        word.payload.alu.src_l = src_l;
        word.payload.alu.src_r = src_r;
        return word;
    endfunction

    // Expected flags are written as {carry, zero}.
    task automatic add_row(input string name, input instr_t word, input reg_data_t exp_result,
                           input alu_flags_t exp_flags);
        row_name.push_back(name);
        row_instr.push_back(word);
        row_valid.push_back(1'b1);
        row_result.push_back(exp_result);
        row_flags.push_back(exp_flags);
    endtask

    // A row without a strobe. The instruction is presented but must be ignored.
    task automatic add_idle(input string name, input instr_t word);
        row_name.push_back(name);
        row_instr.push_back(word);
        row_valid.push_back(1'b0);
        row_result.push_back('0);
        row_flags.push_back('0);
    endtask

    task automatic build_table();
        logic [31:0] rand_word;
        reg_data_t   a;
        reg_data_t   b;
        reg_data_t   exp_sum;
        reg_data_t   exp_diff;
        int          sum;
        int          diff;
        int          k;
        // Load every register, then read each back through both read ports.
        add_row("load r0", load_word(2'd0, 8'h00), 8'h00, 2'b01);
        add_row("load r1", load_word(2'd1, 8'h5A), 8'h5A, 2'b00);
        add_row("load r2", load_word(2'd2, 8'hFF), 8'hFF, 2'b00);
        add_row("load r3", load_word(2'd3, 8'h81), 8'h81, 2'b00);
        add_row("pass r0", alu_word(ALU_PASS_L, 2'd0, 2'd0, 2'd0), 8'h00, 2'b01);
        add_row("pass r1", alu_word(ALU_PASS_L, 2'd1, 2'd1, 2'd1), 8'h5A, 2'b00);
        add_row("pass r2", alu_word(ALU_PASS_L, 2'd2, 2'd2, 2'd2), 8'hFF, 2'b00);
        add_row("pass r3", alu_word(ALU_PASS_L, 2'd3, 2'd3, 2'd3), 8'h81, 2'b00);
        add_row("or r1=r0|r1", alu_word(ALU_OR, 2'd1, 2'd0, 2'd1), 8'h5A, 2'b00);
        add_row("or r2=r0|r2", alu_word(ALU_OR, 2'd2, 2'd0, 2'd2), 8'hFF, 2'b00);
        add_row("or r3=r0|r3", alu_word(ALU_OR, 2'd3, 2'd0, 2'd3), 8'h81, 2'b00);
        add_row("or r0=r0|r0", alu_word(ALU_OR, 2'd0, 2'd0, 2'd0), 8'h00, 2'b01);
        // Arithmetic with carry and borrow. Only r0 changes from here on.
        add_row("add r0=r2+r3", alu_word(ALU_ADD, 2'd0, 2'd2, 2'd3), 8'h80, 2'b10);
        add_row("add r0=r0+r0", alu_word(ALU_ADD, 2'd0, 2'd0, 2'd0), 8'h00, 2'b11);
        add_row("sub r0=r1-r2", alu_word(ALU_SUB, 2'd0, 2'd1, 2'd2), 8'h5B, 2'b10);
        add_row("sub r0=r2-r1", alu_word(ALU_SUB, 2'd0, 2'd2, 2'd1), 8'hA5, 2'b00);
        add_row("sub r0=r1-r1", alu_word(ALU_SUB, 2'd0, 2'd1, 2'd1), 8'h00, 2'b01);
        add_row("add r0=r1+r3", alu_word(ALU_ADD, 2'd0, 2'd1, 2'd3), 8'hDB, 2'b00);
        // Logic operations and shifts.
        add_row("and r0=r1&r3", alu_word(ALU_AND, 2'd0, 2'd1, 2'd3), 8'h00, 2'b01);
        add_row("or r0=r1|r3", alu_word(ALU_OR, 2'd0, 2'd1, 2'd3), 8'hDB, 2'b00);
        add_row("xor r0=r1^r2", alu_word(ALU_XOR, 2'd0, 2'd1, 2'd2), 8'hA5, 2'b00);
        add_row("xor r0=r2^r2", alu_word(ALU_XOR, 2'd0, 2'd2, 2'd2), 8'h00, 2'b01);
        add_row("shl r0=r3<<1", alu_word(ALU_SHL, 2'd0, 2'd3, 2'd0), 8'h02, 2'b10);
        add_row("shl r0=r1<<1", alu_word(ALU_SHL, 2'd0, 2'd1, 2'd0), 8'hB4, 2'b00);
        add_row("shl r0=r0<<1", alu_word(ALU_SHL, 2'd0, 2'd0, 2'd0), 8'h68, 2'b10);
        add_row("not r0=~r2", alu_word(ALU_NOT_L, 2'd0, 2'd2, 2'd0), 8'h00, 2'b01);
        add_row("not r0=~r1", alu_word(ALU_NOT_L, 2'd0, 2'd1, 2'd0), 8'hA5, 2'b00);
        // Back-to-back loads feeding arithmetic on the very next strobe.
        for (k = 0; k < 3; k++) begin
            rand_word = $urandom();
            a         = rand_word[7:0];
            rand_word = $urandom();
            b         = rand_word[7:0];
            sum       = int'(a) + int'(b);
            diff      = int'(b) - int'(a);
            exp_sum   = reg_data_t'(sum % 256);
            exp_diff  = reg_data_t'((diff + 256) % 256); // Two's complement wrap.
            add_row("load r2 random", load_word(2'd2, a), a, {1'b0, a == 8'h00});
            add_row("load r3 random", load_word(2'd3, b), b, {1'b0, b == 8'h00});
            add_row("add r0=r2+r3", alu_word(ALU_ADD, 2'd0, 2'd2, 2'd3), exp_sum,
                    {sum > 255, exp_sum == 8'h00});
            add_row("sub r1=r3-r2", alu_word(ALU_SUB, 2'd1, 2'd3, 2'd2), exp_diff,
                    {diff < 0, exp_diff == 8'h00});
        end
        // Idle cycles must not write, even with a load presented.
        add_row("load r1", load_word(2'd1, 8'h3C), 8'h3C, 2'b00);
        add_idle("idle load r1", load_word(2'd1, 8'hC3));
        add_idle("idle", alu_word(ALU_NOT_L, 2'd1, 2'd1, 2'd1));
        add_row("pass r1 after idle", alu_word(ALU_PASS_L, 2'd1, 2'd1, 2'd0), 8'h3C, 2'b00);
    endtask

    // Returns the number of edges from the strobe until result_valid was seen.
    task automatic wait_result_valid(input string what, output int cycles);
        cycles = 1;
        while (result_valid !== 1'b1 && cycles < 10) begin
            instr_valid = 1'b0; // Keep the row from being executed twice.
            @(posedge _wr_en);
            #1;
            cycles++;
        end
        if (result_valid !== 1'b1) begin
            $display("Timeout: result_valid did not rise within 10 cycles after %s", what);
            stop_on_error();
        end
    endtask

    initial begin : main_sequence
        int          i;
        int          cycles;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        void'($urandom(32'hd6447085));
        build_table();

        repeat (8) @(posedge _wr_en);
        #1;
        reset = 1'b0;
        check_valid(result_valid, 1'b0, "reset");
        check_flags(flags, 2'b00, "reset");
        check_result(result, 8'h00, "reset");

        for (i = 0; i < row_instr.size(); i++) begin
            instr       = row_instr[i];
            instr_valid = row_valid[i];
            @(posedge _wr_en);
            #1;
            if (row_valid[i]) begin
                wait_result_valid(row_name[i], cycles);
                if (cycles != 1) begin
                    $display("Latency error: %s produced its result %0d cycles after the strobe",
                             row_name[i], cycles);
                    stop_on_error();
                end
                check_result(result, row_result[i], row_name[i]);
                check_flags(flags, row_flags[i], row_name[i]);
            end else begin
                check_valid(result_valid, 1'b0, row_name[i]);
            end
        end

        instr_valid = 1'b0;
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== datapath_top.sv ====
// Top of the 8-bit datapath; register contents are not cleared by reset and must be loaded first.
`timescale 1ns/1ns
`default_nettype none

module datapath_top (
    input  wire                          _wr_en,
    input  wire                          reset,
    input  wire datapath_pkg::instr_t    instr,
    input  wire                          instr_valid,
    output regfile_pkg::reg_data_t       result,
    output datapath_pkg::alu_flags_t     flags,
    output logic                         result_valid
);

    import regfile_pkg::*;
    import datapath_pkg::*;

    wire rf_write_t  wr;
    wire rf_read_t   rd_l;
    wire rf_read_t   rd_r;
    wire reg_data_t  rd_l_data;
    wire reg_data_t  rd_r_data;
    wire reg_data_t  alu_result;
    wire alu_flags_t alu_flags;
    wire alu_op_t    alu_op;

    datapath_sequencer u_sequencer (
        ._wr_en       (_wr_en),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .rd_l         (rd_l),
        .rd_r         (rd_r),
        .wr           (wr),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .alu_op       (alu_op),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid)
    );

    register_file u_register_file (
        ._wr_en    (_wr_en),
        .wr        (wr),
        .rd_l      (rd_l),
        .rd_r      (rd_r),
        .rd_l_data (rd_l_data),
        .rd_r_data (rd_r_data)
    );

    alu u_alu (
        .op        (alu_op),
        .operand_l (rd_l_data),
        .operand_r (rd_r_data),
        .result    (alu_result),
        .flags     (alu_flags)
    );

endmodule

`default_nettype wire

// ==== datapath_sequencer.sv ====
// Single-cycle decoder; accepts an instruction on every strobe and cannot stall, results lag one edge.
`timescale 1ns/1ns
`default_nettype none

module datapath_sequencer (
    input  wire                          _wr_en,
    input  wire                          reset,
    input  wire datapath_pkg::instr_t    instr,
    input  wire                          instr_valid,
    output regfile_pkg::rf_read_t        rd_l,
    output regfile_pkg::rf_read_t        rd_r,
    output regfile_pkg::rf_write_t       wr,
    input  wire regfile_pkg::reg_data_t  alu_result,
    input  wire datapath_pkg::alu_flags_t alu_flags,
    output datapath_pkg::alu_op_t        alu_op,
    output regfile_pkg::reg_data_t       result,
    output datapath_pkg::alu_flags_t     flags,
    output logic                         result_valid
);

    import regfile_pkg::*;
    import datapath_pkg::*;

    reg_data_t  wb_data;
    alu_flags_t wb_flags;

    // Operands are read straight from the ALU form, even for a load.
    always_comb begin
        rd_l.en   = instr_valid;
        rd_l.addr = instr.payload.alu.src_l;
        rd_r.en   = instr_valid;
        rd_r.addr = instr.payload.alu.src_r;
    end

    assign alu_op = instr.payload.alu.op;

    always_comb begin
        if (instr.kind) begin
            wb_data        = instr.payload.imm.value; // Load immediate.
            wb_flags.carry = 1'b0;
            wb_flags.zero  = (instr.payload.imm.value == '0);
        end else begin
            wb_data  = alu_result;
            wb_flags = alu_flags;
        end
    end

    // The write lands on the same edge that samples the instruction.
    always_comb begin
        wr.we   = instr_valid;
        wr.addr = instr.dest;
        wr.data = wb_data;
    end

    always_ff @(posedge _wr_en) begin
        if (reset) begin
            result       <= '0;
            flags        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= instr_valid;
            if (instr_valid) begin
                result <= wb_data;  // Held through idle cycles.
                flags  <= wb_flags;
            end
        end
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
// Purely combinational 8-bit ALU; carry is only meaningful for add, subtract and shift left.
`timescale 1ns/1ns
`default_nettype none

`include "regfile_cfg.svh"

module alu (
    input  wire datapath_pkg::alu_op_t  op,
    input  wire regfile_pkg::reg_data_t operand_l,
    input  wire regfile_pkg::reg_data_t operand_r,
    output regfile_pkg::reg_data_t      result,
    output datapath_pkg::alu_flags_t    flags
);

    import regfile_pkg::*;
    import datapath_pkg::*;

    // One bit wider than a register so the top bit carries the carry, borrow or shifted-out bit.
    logic [`RF_DATA_WIDTH:0] wide;
    reg_data_t               res;

    always_comb begin
        case (op)
            ALU_ADD: begin
                wide = {1'b0, operand_l} + {1'b0, operand_r};
            end
            ALU_SUB: begin
                // Wraps below zero, which leaves the borrow in the top bit.
                wide = {1'b0, operand_l} - {1'b0, operand_r};
            end
            ALU_AND: begin
                wide = {1'b0, operand_l & operand_r};
            end
            ALU_OR: begin
                wide = {1'b0, operand_l | operand_r};
            end
            ALU_XOR: begin
                wide = {1'b0, operand_l ^ operand_r};
            end
            ALU_PASS_L: begin
                wide = {1'b0, operand_l};
            end
            ALU_SHL: begin
                wide = {operand_l, 1'b0}; // Old bit 7 lands in the carry position.
            end
            ALU_NOT_L: begin
                wide = {1'b0, ~operand_l};
            end
            default: begin
                wide = '0;
            end
        endcase
    end

    assign res         = wide[`RF_DATA_WIDTH-1:0];
    assign result      = res;
    assign flags.carry = wide[`RF_DATA_WIDTH]; // Zero for the logic operations.
    assign flags.zero  = (res == '0);

endmodule

`default_nettype wire

// ==== register_file.sv ====
// 4x8 register file with two read ports; each port has its own pair of chips holding a full copy.
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                         _wr_en,
    input  wire regfile_pkg::rf_write_t wr,
    input  wire regfile_pkg::rf_read_t  rd_l,
    input  wire regfile_pkg::rf_read_t  rd_r,
    output regfile_pkg::reg_data_t      rd_l_data,
    output regfile_pkg::reg_data_t      rd_r_data
);

    import regfile_pkg::*;

    wire nibble_t wr_lo;
    wire nibble_t wr_hi;
    wire nibble_t rd_l_lo;
    wire nibble_t rd_l_hi;
    wire nibble_t rd_r_lo;
    wire nibble_t rd_r_hi;

    assign {wr_hi, wr_lo} = wr.data;  // Split the word across the two chips of a bank.
    assign rd_l_data = {rd_l_hi, rd_l_lo};
    assign rd_r_data = {rd_r_hi, rd_r_lo};

    // Every chip sees the same write, so the left and right banks never differ.
    hct74670 left_bank_lo (
        ._wr_en  (_wr_en),
        .we      (wr.we),
        .wr_addr (wr.addr),
        .wr_data (wr_lo),
        .rd_en   (rd_l.en),
        .rd_addr (rd_l.addr),
        .rd_data (rd_l_lo)
    );

    hct74670 left_bank_hi (
        ._wr_en  (_wr_en),
        .we      (wr.we),
        .wr_addr (wr.addr),
        .wr_data (wr_hi),
        .rd_en   (rd_l.en),
        .rd_addr (rd_l.addr),
        .rd_data (rd_l_hi)
    );

    hct74670 right_bank_lo (
        ._wr_en  (_wr_en),
        .we      (wr.we),
        .wr_addr (wr.addr),
        .wr_data (wr_lo),
        .rd_en   (rd_r.en),
        .rd_addr (rd_r.addr),
        .rd_data (rd_r_lo)
    );

    hct74670 right_bank_hi (
        ._wr_en  (_wr_en),
        .we      (wr.we),
        .wr_addr (wr.addr),
        .wr_data (wr_hi),
        .rd_en   (rd_r.en),
        .rd_addr (rd_r.addr),
        .rd_data (rd_r_hi)
    );

endmodule

`default_nettype wire

// ==== hct74670.sv ====
// Model of a 4x4 register-file chip; contents are undefined until written and a disabled read returns zero.
`timescale 1ns/1ns
`default_nettype none

`include "regfile_cfg.svh"

module hct74670 (
    input  wire                    _wr_en,
    input  wire                    we,
    input  wire regfile_pkg::reg_addr_t wr_addr,
    input  wire regfile_pkg::nibble_t   wr_data,
    input  wire                    rd_en,
    input  wire regfile_pkg::reg_addr_t rd_addr,
    output regfile_pkg::nibble_t   rd_data
);

    import regfile_pkg::*;

    // The real part has no reset pin, so neither does the storage here.
    nibble_t registers [`RF_DEPTH];

    always_ff @(posedge _wr_en) begin
        if (we) begin
            registers[wr_addr] <= wr_data;
        end
    end

    // The read path is a plain mux, so a write shows on the output right after the edge.
    // On the chip a disabled output floats. This model drives zero instead.
    assign rd_data = rd_en ? registers[rd_addr] : '0;

endmodule

`default_nettype wire

// ==== datapath_pkg.sv ====
// Instruction and ALU types; the payload is 10 bits and both of its forms must stay that wide.
`default_nettype none

package datapath_pkg;

    // The eight ALU operations. The encoding fills all three bits.
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_L = 3'd5,
        ALU_SHL    = 3'd6,
        ALU_NOT_L  = 3'd7
    } alu_op_t;

    typedef struct packed {
        logic carry; // Carry out, or the borrow after a subtract.
        logic zero;  // Result is all zeros.
    } alu_flags_t;

    // The same payload bits read as an ALU operation or as an immediate load.
    typedef union packed {
        struct packed {
            alu_op_t                op;
            regfile_pkg::reg_addr_t src_l; // Left operand register.
            regfile_pkg::reg_addr_t src_r; // Right operand register.
            logic [2:0]             spare;
        } alu;
        struct packed {
            regfile_pkg::reg_data_t value; // Constant written to the destination.
            logic [1:0]             spare;
        } imm;
    } instr_payload_u;

    // One instruction word as presented with instr_valid.
    typedef struct packed {
        logic                   kind;    // 0 is an ALU operation, 1 is a load immediate.
        regfile_pkg::reg_addr_t dest;
        instr_payload_u         payload;
    } instr_t;

endpackage

`default_nettype wire

// ==== regfile_pkg.sv ====
// Register storage types; the data width must be exactly twice the chip word width.
`default_nettype none

`include "regfile_cfg.svh"

package regfile_pkg;

    typedef logic [`RF_ADDR_WIDTH-1:0]   reg_addr_t; // Register index.
    typedef logic [`RF_DATA_WIDTH-1:0]   reg_data_t; // Full register word.
    typedef logic [`RF_NIBBLE_WIDTH-1:0] nibble_t;   // One word of a single chip.

    // The single write port, shared by every chip in the file.
    typedef struct packed {
        logic      we;   // Write on the next rising edge of _wr_en.
        reg_addr_t addr;
        reg_data_t data;
    } rf_write_t;

    // One read port request. A port with en low reads back zero.
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
    } rf_read_t;

endpackage

`default_nettype wire

// ==== regfile_cfg.svh ====
// Widths for the 8-bit datapath; RF_DEPTH must equal 2**RF_ADDR_WIDTH and the chip word stays 4 bits.
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// Width of one register word.
`define RF_DATA_WIDTH 8

// Width of one 74670 chip word. A register word is two of these.
`define RF_NIBBLE_WIDTH 4

// Number of registers, which is also the number of words in one chip.
`define RF_DEPTH 4

// Bits needed to index a register.
`define RF_ADDR_WIDTH 2

`endif
